// ==== source/router_pkg.sv ====
// ##################################################
// Fixed widths and types shared by all router blocks
// Mesh origin is the north-west corner, so x grows east
// and y grows south; coordinates are unsigned
// ##################################################
package router_pkg;

    localparam int NUM_PORTS   = 5;
    localparam int COORD_WIDTH = 4;
    localparam int DATA_WIDTH  = 32;

    // Port order also sets the round-robin order
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } port_e;

    // One bit per port, indexed by port_e
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    typedef struct packed {
        logic [COORD_WIDTH-1:0] x;
        logic [COORD_WIDTH-1:0] y;
    } coord_t;

    // Destination rides in the upper bits
    typedef struct packed {
        coord_t                dest;
        logic [DATA_WIDTH-1:0] payload;
    } flit_t;

endpackage

// ==== source/input_port.sv ====
// ##################################################
// Input FIFO with XY route lookup on the head flit
// FIFO_DEPTH must be a power of two, at least 2
// pop_i is trusted and must only be raised when a
// request is pending
// ##################################################
module input_port
    import router_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,

    input  coord_t    local_coord_i,

    input  logic      in_valid_i,
    input  flit_t     in_flit_i,
    output logic      in_ready_o,

    input  logic      pop_i,
    output port_vec_t route_req_o,
    output flit_t     head_flit_o
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    flit_t                fifo_mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;

    logic  full;
    logic  empty;
    logic  push;
    coord_t head_dest;
    port_e  route;

    assign full       = (count == CNT_WIDTH'(FIFO_DEPTH));
    assign empty      = (count == '0);
    assign in_ready_o = ~full;
    assign push       = in_valid_i & ~full;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= in_flit_i;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop_i})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    assign head_flit_o = fifo_mem[rd_ptr];
    assign head_dest   = head_flit_o.dest;

    // Dimension order: finish x first, then y
    always_comb begin
        if (head_dest.x == local_coord_i.x && head_dest.y == local_coord_i.y) begin
            route = LOCAL;
        end else if (head_dest.x > local_coord_i.x) begin
            route = EAST;
        end else if (head_dest.x < local_coord_i.x) begin
            route = WEST;
        end else if (head_dest.y > local_coord_i.y) begin
            route = SOUTH;
        end else begin
            route = NORTH;
        end
    end

    // One-hot request, silent while empty
    always_comb begin
        route_req_o = '0;
        if (!empty) begin
            route_req_o[route] = 1'b1;
        end
    end

endmodule

// ==== source/output_arbiter.sv ====
// ##################################################
// Round-robin arbiter and flit mux for one output
// out_valid_o never depends on out_ready_i
// A grant bit means the input pops on this edge
// ##################################################
module output_arbiter
    import router_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  port_vec_t             req_i,
    input  flit_t [NUM_PORTS-1:0] head_flits_i,

    input  logic                  out_ready_i,
    output logic                  out_valid_o,
    output flit_t                 out_flit_o,

    output port_vec_t             grant_o
);

    port_e rr_ptr;
    port_e winner;
    logic  found;
    logic  xfer;

    // First requester at or after the pointer
    always_comb begin : pick_winner
        int idx;
        winner = rr_ptr;
        found  = 1'b0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= NUM_PORTS) begin
                idx = idx - NUM_PORTS;
            end
            if (!found && req_i[idx]) begin
                winner = port_e'(idx);
                found  = 1'b1;
            end
        end
    end

    assign out_valid_o = found;
    assign out_flit_o  = head_flits_i[winner];
    assign xfer        = found & out_ready_i;

    // Grant held back under back-pressure
    always_comb begin
        grant_o = '0;
        if (xfer) begin
            grant_o[winner] = 1'b1;
        end
    end

    // Move one past the winner, only on a completed transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= NORTH;
        end else if (xfer) begin
            if (winner == LOCAL) begin
                rr_ptr <= NORTH;
            end else begin
                rr_ptr <= port_e'(winner + 3'd1);
            end
        end
    end

endmodule

// ==== source/mesh_router.sv ====
// ##################################################
// Five-port XY mesh router node
// Per-port arrays are indexed by port_e
// One cycle from input transfer to output valid
// when the FIFO is empty and the output is free
// ##################################################
module mesh_router
    import router_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  coord_t                local_coord_i,

    input  port_vec_t             in_valid_i,
    input  flit_t [NUM_PORTS-1:0] in_flit_i,
    output port_vec_t             in_ready_o,

    output port_vec_t             out_valid_o,
    output flit_t [NUM_PORTS-1:0] out_flit_o,
    input  port_vec_t             out_ready_i
);

    // Indexed [input][output]
    port_vec_t [NUM_PORTS-1:0] route_req;
    port_vec_t [NUM_PORTS-1:0] pop_vec;

    // Indexed [output][input]
    port_vec_t [NUM_PORTS-1:0] arb_req;
    port_vec_t [NUM_PORTS-1:0] grant;

    flit_t [NUM_PORTS-1:0] head_flit;

    // Swap request and grant matrices between the two sides
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                arb_req[o][i] = route_req[i][o];
                pop_vec[i][o] = grant[o][i];
            end
        end
    end

    genvar gi;
    generate
        for (gi = 0; gi < NUM_PORTS; gi++) begin : gen_in
            input_port #(
                .FIFO_DEPTH (FIFO_DEPTH)
            ) u_input_port (
                .clk           (clk),
                .rst_n         (rst_n),
                .local_coord_i (local_coord_i),
                .in_valid_i    (in_valid_i[gi]),
                .in_flit_i     (in_flit_i[gi]),
                .in_ready_o    (in_ready_o[gi]),
                .pop_i         (|pop_vec[gi]),
                .route_req_o   (route_req[gi]),
                .head_flit_o   (head_flit[gi])
            );
        end
    endgenerate

    genvar go;
    generate
        for (go = 0; go < NUM_PORTS; go++) begin : gen_out
            output_arbiter u_output_arbiter (
                .clk          (clk),
                .rst_n        (rst_n),
                .req_i        (arb_req[go]),
                .head_flits_i (head_flit),
                .out_ready_i  (out_ready_i[go]),
                .out_valid_o  (out_valid_o[go]),
                .out_flit_o   (out_flit_o[go]),
                .grant_o      (grant[go])
            );
        end
    endgenerate

endmodule

// ==== testbench/tb_vectors.svh ====
// ##################################################
// Stimulus table, XY reference rule and compare tasks
// Included in the testbench module body; checks and
// errors must be declared before the include
// ##################################################
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int TABLE_LEN = 78;

typedef struct packed {
    logic [3:0] test_id;
    port_e      src;
    coord_t     dest;
} entry_t;

entry_t vec_table [TABLE_LEN];

function automatic coord_t make_coord(input int x, input int y);
    coord_t c;
    c.x = COORD_WIDTH'(x);
    c.y = COORD_WIDTH'(y);
    return c;
endfunction

// x first, then y, as signed offsets from this node
function automatic port_e expected_port(input coord_t here, input coord_t dest);
    int dx;
    int dy;
    dx = int'(dest.x) - int'(here.x);
    dy = int'(dest.y) - int'(here.y);
    if (dx == 0 && dy == 0) begin
        return LOCAL;
    end
    if (dx != 0) begin
        return (dx > 0) ? EAST : WEST;
    end
    return (dy > 0) ? SOUTH : NORTH;
endfunction

task automatic fill_table();
    coord_t dests [NUM_PORTS];
    int     n;
    dests[0] = make_coord(5, 5);
    dests[1] = make_coord(7, 5);
    dests[2] = make_coord(2, 5);
    dests[3] = make_coord(5, 9);
    dests[4] = make_coord(5, 1);
    n = 0;
    // Every destination from every input
    for (int s = 0; s < NUM_PORTS; s++) begin
        for (int d = 0; d < NUM_PORTS; d++) begin
            vec_table[n] = '{test_id: 4'd2, src: port_e'(s), dest: dests[d]};
            n++;
        end
    end
    // West input into a stalled east output
    for (int k = 0; k < 5; k++) begin
        vec_table[n] = '{test_id: 4'd3, src: WEST, dest: make_coord(7, 5)};
        n++;
    end
    // Two flits each from N, E, S and W to local
    for (int s = 0; s < 4; s++) begin
        for (int k = 0; k < 2; k++) begin
            vec_table[n] = '{test_id: 4'd4, src: port_e'(s), dest: dests[0]};
            n++;
        end
    end
    for (int k = 0; k < 40; k++) begin
        vec_table[n].test_id = 4'd5;
        vec_table[n].src     = port_e'($urandom_range(NUM_PORTS - 1, 0));
        vec_table[n].dest    = make_coord($urandom_range(15, 0), $urandom_range(15, 0));
        n++;
    end
endtask

task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_port(input string name, input port_e exp, input port_e act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("[FAIL] %0t %s expected %s got %s", $time, name, exp.name(), act.name());
    end
endtask

task automatic check_vec(input string name, input port_vec_t exp, input port_vec_t act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
    end
endtask

`endif

// ==== testbench/mesh_router_tb.sv ====
// ##################################################
// Testbench for one router node at mesh position (5,5)
// Top payload bits carry source port and a sequence
// number, so every flit is unique
// ##################################################
module mesh_router_tb
    import router_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam coord_t HERE        = '{x: 4'd5, y: 4'd5};
    localparam int     DRAIN_LIMIT = 200;

    typedef struct packed {
        port_e src;
        flit_t flit;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    port_vec_t             in_valid;
    flit_t [NUM_PORTS-1:0] in_flit;
    port_vec_t             in_ready;
    port_vec_t             out_valid;
    flit_t [NUM_PORTS-1:0] out_flit;
    port_vec_t             out_ready;

    int        checks;
    int        errors;
    int        fifo_depth;
    int        seq_num;
    int        cycle_cnt = 0;
    logic      stall_en;
    logic      rr_check;
    port_vec_t acc_vec;
    port_e     rr_model [NUM_PORTS];
    expect_t   exp_q [NUM_PORTS][$];

    `include "tb_vectors.svh"

    localparam int CYCLE_LIMIT = TABLE_LEN * 20 + 200;

    mesh_router #(
        .FIFO_DEPTH (4)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .local_coord_i (HERE),
        .in_valid_i    (in_valid),
        .in_flit_i     (in_flit),
        .in_ready_o    (in_ready),
        .out_valid_o   (out_valid),
        .out_flit_o    (out_flit),
        .out_ready_i   (out_ready)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("ERROR: run passed %0d cycles, flits stopped moving", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic int pending_total();
        int total;
        total = 0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            total += exp_q[o].size();
        end
        return total;
    endfunction

    function automatic logic pending_from(input int o, input int s);
        logic hit;
        hit = 1'b0;
        for (int n = 0; n < exp_q[o].size(); n++) begin
            if (int'(exp_q[o][n].src) == s) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Outputs are stable at the falling edge; a transfer follows on the next rise
    task automatic monitor_outputs();
        port_e src;
        port_e want;
        port_e op;
        int    idx;
        int    cand;
        logic  found;
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (out_valid[o] && out_ready[o]) begin
                op  = port_e'(o);
                src = port_e'(out_flit[o].payload[DATA_WIDTH-1 -: 3]);
                if (rr_check && op == LOCAL) begin
                    want  = rr_model[o];
                    found = 1'b0;
                    for (int k = 0; k < NUM_PORTS; k++) begin
                        cand = (int'(rr_model[o]) + k) % NUM_PORTS;
                        if (!found && pending_from(o, cand)) begin
                            want  = port_e'(cand);
                            found = 1'b1;
                        end
                    end
                    check_port("out_flit_o[LOCAL] source", want, src);
                end
                idx = -1;
                for (int n = 0; n < exp_q[o].size(); n++) begin
                    if (idx < 0 && exp_q[o][n].src == src) begin
                        idx = n;
                    end
                end
                if (idx < 0) begin
                    checks++;
                    errors++;
                    $display("ERROR: at %0t output %s delivered a flit from input %s not sent there",
                             $time, op.name(), src.name());
                end else begin
                    check_flit($sformatf("out_flit_o[%s]", op.name()), exp_q[o][idx].flit,
                               out_flit[o]);
                    exp_q[o].delete(idx);
                end
                rr_model[o] = (src == LOCAL) ? NORTH : port_e'(int'(src) + 1);
            end
        end
    endtask

    task automatic tick();
        @(negedge clk);
        acc_vec = in_valid & in_ready;
        monitor_outputs();
        @(posedge clk);
        #2;
        // Each output ready about three cycles in four
        if (stall_en) begin
            out_ready = port_vec_t'($urandom) | port_vec_t'($urandom);
        end
    endtask

    task automatic send_flit(input port_e p, input flit_t f);
        in_valid[p] = 1'b1;
        in_flit[p]  = f;
        do begin
            tick();
        end while (!acc_vec[p]);
        in_valid[p] = 1'b0;
    endtask

    task automatic send_entry(input entry_t e, output flit_t f);
        expect_t item;
        f.dest    = e.dest;
        f.payload = {e.src, 8'(seq_num), 21'($urandom)};
        seq_num++;
        send_flit(e.src, f);
        item.src  = e.src;
        item.flit = f;
        exp_q[expected_port(HERE, e.dest)].push_back(item);
    endtask

    task automatic check_backpressure(input flit_t first);
        port_vec_t want_ready;
        port_vec_t want_valid;
        want_ready       = '1;
        want_ready[WEST] = 1'b0;
        want_valid       = '0;
        want_valid[EAST] = 1'b1;
        repeat (2) tick();
        #1;
        check_vec("in_ready_o", want_ready, in_ready);
        check_vec("out_valid_o", want_valid, out_valid);
        check_flit("out_flit_o[EAST]", first, out_flit[EAST]);
        tick();
        out_ready[EAST] = 1'b1;
    endtask

    task automatic run_entries(input int id);
        int    sent;
        flit_t flit;
        flit_t first_flit;
        sent       = 0;
        first_flit = '0;
        for (int n = 0; n < TABLE_LEN; n++) begin
            if (int'(vec_table[n].test_id) == id) begin
                if (id == 3 && sent == fifo_depth) begin
                    check_backpressure(first_flit);
                end
                send_entry(vec_table[n], flit);
                if (sent == 0) begin
                    first_flit = flit;
                end
                sent++;
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending_total() > 0 && waited < DRAIN_LIMIT) begin
            tick();
            waited++;
        end
        if (pending_total() > 0) begin
            errors++;
            $display("ERROR: %0d flits were accepted but never left the router",
                     pending_total());
            for (int o = 0; o < NUM_PORTS; o++) begin
                exp_q[o].delete();
            end
        end
    endtask

    task automatic report_test(input int id, input string name, input int mark);
        if (errors == mark) begin
            $display("Test %0d %s: ok", id, name);
        end else begin
            $display("Test %0d %s: %0d errors", id, name, errors - mark);
        end
    endtask

    initial begin
        int err_mark;
        void'($urandom(87));
        checks    = 0;
        errors    = 0;
        seq_num   = 0;
        stall_en  = 1'b0;
        rr_check  = 1'b0;
        acc_vec   = '0;
        rst_n     = 1'b0;
        in_valid  = '0;
        in_flit   = '0;
        out_ready = '1;
        for (int o = 0; o < NUM_PORTS; o++) begin
            rr_model[o] = NORTH;
        end
        fill_table();
        fifo_depth = dut_i.FIFO_DEPTH;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        err_mark = errors;
        #1;
        check_vec("out_valid_o", '0, out_valid);
        check_vec("in_ready_o", '1, in_ready);
        tick();
        report_test(1, "reset state", err_mark);

        err_mark = errors;
        run_entries(2);
        wait_drain();
        report_test(2, "XY routing", err_mark);

        err_mark = errors;
        out_ready[EAST] = 1'b0;
        run_entries(3);
        out_ready[EAST] = 1'b1;
        wait_drain();
        report_test(3, "back-pressure", err_mark);

        // Fill four FIFOs before local output opens
        err_mark = errors;
        out_ready[LOCAL] = 1'b0;
        run_entries(4);
        tick();
        rr_check         = 1'b1;
        out_ready[LOCAL] = 1'b1;
        wait_drain();
        rr_check = 1'b0;
        report_test(4, "round-robin", err_mark);

        err_mark = errors;
        stall_en = 1'b1;
        run_entries(5);
        wait_drain();
        stall_en  = 1'b0;
        out_ready = '1;
        report_test(5, "random traffic", err_mark);

        $display("Summary: %0d checks, %0d errors, %0d flits sent", checks, errors, seq_num);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+testbench
source/router_pkg.sv
source/input_port.sv
source/output_arbiter.sv
source/mesh_router.sv
testbench/mesh_router_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mesh router testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
OBJ_DIR=$BUILD_DIR/obj_dir
LOG=$BUILD_DIR/sim.log
SIM=mesh_router_sim

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Cannot create $BUILD_DIR"
    exit 1
fi

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    -f sources.f --top-module mesh_router_tb \
    -Mdir "$OBJ_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$OBJ_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished without reported failure"
exit 0
